//--- slurm16_params.svh
`ifndef SLURM16_PARAMS_SVH
`define SLURM16_PARAMS_SVH

// ##################################################
// datapath widths
// ##################################################

// data word width
`define SLURM16_BITS 16

// program counter width
`define SLURM16_ADDRESS_BITS 16

// register select width, gives 128 registers
`define SLURM16_REGISTER_BITS 7

// ##################################################
// special registers
// ##################################################

// branch-and-link return address
`define SLURM16_LINK_REGISTER 15

// return address saved on interrupt entry
`define SLURM16_INTERRUPT_LINK_REGISTER 14

`endif

//--- slurm16_pkg.sv
`include "slurm16_params.svh"

package slurm16_pkg;

	typedef logic [`SLURM16_BITS-1:0] word_t;
	typedef logic [`SLURM16_BITS-1:0] instr_t;
	typedef logic [`SLURM16_REGISTER_BITS-1:0] reg_sel_t;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} flags_t;

	// instruction classes, decoded from bits 15:12
	typedef enum logic [3:0] {
		cls_alu_single,
		cls_alu_reg_reg,
		cls_alu_reg_imm,
		cls_branch,
		cls_byte_load_store,
		cls_byte_load_sx,
		cls_load_store,
		cls_peek_poke,
		cls_cond_mov,
		cls_three_reg_cond_alu,
		cls_other
	} ins_class_e;

	// condition codes
	typedef enum logic [3:0] {
		cond_eq, cond_ne, cond_cs, cond_cc,
		cond_mi, cond_pl, cond_vs, cond_vc,
		cond_hi, cond_ls, cond_ge, cond_lt,
		cond_gt, cond_le, cond_al, cond_nv
	} cond_e;

	function automatic ins_class_e ins_class(instr_t ins);
		ins_class_e c;
		case (ins[15:12])
			4'h1: c = cls_alu_single;
			4'h2: c = cls_alu_reg_reg;
			4'h3: c = cls_alu_reg_imm;
			4'h4: c = cls_branch;
			4'h5: c = cls_byte_load_store;
			4'h6: c = cls_byte_load_sx;
			4'h7: c = cls_load_store;
			4'h8: c = cls_peek_poke;
			4'h9: c = cls_cond_mov;
			4'ha: c = cls_three_reg_cond_alu;
			default: c = cls_other;
		endcase
		return c;
	endfunction

	// register fields are 4 bits wide, upper select bits read as zero
	function automatic reg_sel_t reg_src_from_ins(instr_t ins);
		return reg_sel_t'(ins[3:0]);
	endfunction

	function automatic reg_sel_t reg_dest_from_ins(instr_t ins);
		return reg_sel_t'(ins[7:4]);
	endfunction

	function automatic reg_sel_t reg_3dest_from_ins(instr_t ins);
		return reg_sel_t'(ins[11:8]);
	endfunction

	function automatic logic [3:0] cond_from_ins(instr_t ins);
		return ins[11:8];
	endfunction

	// bit 11 selects the variant within branch, load/store and peek/poke
	function automatic logic is_branch_link_from_ins(instr_t ins);
		return ins[11];
	endfunction

	// 1 means store
	function automatic logic is_load_store_from_ins(instr_t ins);
		return ins[11];
	endfunction

	// 1 means poke
	function automatic logic is_io_poke_from_ins(instr_t ins);
		return ins[11];
	endfunction

	function automatic logic condition_true(logic [3:0] code, flags_t f);
		logic taken;
		case (cond_e'(code))
			cond_eq: taken = f.z;
			cond_ne: taken = !f.z;
			cond_cs: taken = f.c;
			cond_cc: taken = !f.c;
			cond_mi: taken = f.s;
			cond_pl: taken = !f.s;
			cond_vs: taken = f.v;
			cond_vc: taken = !f.v;
			cond_hi: taken = f.c && !f.z;
			cond_ls: taken = !f.c || f.z;
			cond_ge: taken = (f.s == f.v);
			cond_lt: taken = (f.s != f.v);
			cond_gt: taken = !f.z && (f.s == f.v);
			cond_le: taken = f.z || (f.s != f.v);
			cond_al: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		return taken;
	endfunction

endpackage

//--- slurm16_stage4_if.sv
`include "slurm16_params.svh"

interface slurm16_stage4_if import slurm16_pkg::*; (
	input logic clk
);

	instr_t instruction;
	word_t alu_out;
	word_t memory_in;
	word_t port_in;
	logic [`SLURM16_ADDRESS_BITS-1:0] pc_stage4;
	logic [1:0] mem_mask;
	logic is_nop;
	logic load_irq_ret;
	logic cond_pass;
	flags_t flags;

	modport latch (output instruction, alu_out, memory_in, port_in, pc_stage4,
		mem_mask, is_nop, load_irq_ret, cond_pass, flags);

	// clock is only for checks on the writeback side
	modport wb (input clk, instruction, alu_out, memory_in, port_in, pc_stage4,
		mem_mask, is_nop, load_irq_ret, cond_pass, flags);

endinterface

//--- slurm16_cpu_stage4.sv
`include "slurm16_params.svh"

module slurm16_cpu_stage4 import slurm16_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic kill,
	input instr_t instruction,
	input word_t alu_out,
	input word_t memory_in,
	input word_t port_in,
	input logic [`SLURM16_ADDRESS_BITS-1:0] pc_stage3,
	input logic [1:0] mem_mask,
	input logic is_nop,
	input logic load_irq_ret,
	input logic cond_pass,
	input flags_t flags,
	slurm16_stage4_if.latch slot
);

	// ##################################################
	// slot control, reset to a nop
	// ##################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot.is_nop <= 1'b1;
			slot.load_irq_ret <= 1'b0;
		end else if (!stall) begin
			// kill turns the incoming slot into a bubble
			slot.is_nop <= is_nop | kill;
			slot.load_irq_ret <= load_irq_ret & ~kill;
		end
	end

	// payload is only looked at when the slot is live
	always_ff @(posedge clk) begin
		if (!stall) begin
			slot.instruction <= instruction;
			slot.alu_out <= alu_out;
			slot.memory_in <= memory_in;
			slot.port_in <= port_in;
			slot.pc_stage4 <= pc_stage3;
			slot.mem_mask <= mem_mask;
			slot.cond_pass <= cond_pass;
			slot.flags <= flags;
		end
	end

	// hazard unit never asks for both at once
	a_stall_kill_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n) !(stall && kill)
	);

endmodule

//--- slurm16_cpu_writeback.sv
`include "slurm16_params.svh"

module slurm16_cpu_writeback import slurm16_pkg::*; (
	slurm16_stage4_if.wb slot,
	output reg_sel_t reg_wr_sel,
	output word_t reg_out
);

	ins_class_e cls;
	logic [7:0] byte_lane;
	logic byte_load;

	assign cls = ins_class(slot.instruction);

	// pick the addressed byte lane of the memory word
	always_comb begin
		case (slot.mem_mask)
			2'b10: byte_lane = slot.memory_in[15:8];
			2'b01: byte_lane = slot.memory_in[7:0];
			default: byte_lane = 8'h00;
		endcase
	end

	// ##################################################
	// destination and data select
	// ##################################################

	always_comb begin
		// r0 reads back as zero, so an idle slot just writes r0
		reg_wr_sel = '0;
		reg_out = '0;

		if (slot.load_irq_ret) begin
			reg_wr_sel = reg_sel_t'(`SLURM16_INTERRUPT_LINK_REGISTER);
			reg_out = slot.pc_stage4;
		end else if (!slot.is_nop) begin
			case (cls)
				cls_alu_single: begin
					reg_wr_sel = reg_src_from_ins(slot.instruction);
					reg_out = slot.alu_out;
				end
				cls_alu_reg_reg, cls_alu_reg_imm: begin
					reg_wr_sel = reg_dest_from_ins(slot.instruction);
					reg_out = slot.alu_out;
				end
				cls_branch: begin
					if (is_branch_link_from_ins(slot.instruction)) begin
						reg_wr_sel = reg_sel_t'(`SLURM16_LINK_REGISTER);
						reg_out = slot.pc_stage4 + `SLURM16_ADDRESS_BITS'd2;
					end
				end
				cls_byte_load_store: begin
					if (!is_load_store_from_ins(slot.instruction)) begin
						reg_wr_sel = reg_dest_from_ins(slot.instruction);
						reg_out = {{(`SLURM16_BITS-8){1'b0}}, byte_lane};
					end
				end
				cls_byte_load_sx: begin
					reg_wr_sel = reg_dest_from_ins(slot.instruction);
					reg_out = {{(`SLURM16_BITS-8){byte_lane[7]}}, byte_lane};
				end
				cls_load_store: begin
					if (!is_load_store_from_ins(slot.instruction)) begin
						reg_wr_sel = reg_dest_from_ins(slot.instruction);
						reg_out = slot.memory_in;
					end
				end
				cls_peek_poke: begin
					if (!is_io_poke_from_ins(slot.instruction)) begin
						reg_wr_sel = reg_dest_from_ins(slot.instruction);
						reg_out = slot.port_in;
					end
				end
				cls_cond_mov: begin
					// flags are the ones left by the previous alu op
					if (condition_true(cond_from_ins(slot.instruction), slot.flags)) begin
						reg_wr_sel = reg_dest_from_ins(slot.instruction);
						reg_out = slot.alu_out;
					end
				end
				cls_three_reg_cond_alu: begin
					// condition was resolved back in stage 2
					if (slot.cond_pass) begin
						reg_wr_sel = reg_3dest_from_ins(slot.instruction);
						reg_out = slot.alu_out;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// memory stage must hand over exactly one lane for a byte load
	assign byte_load = !slot.is_nop &&
		((cls == cls_byte_load_store && !is_load_store_from_ins(slot.instruction)) ||
		cls == cls_byte_load_sx);

	a_byte_mask_onehot: assert property (
		@(posedge slot.clk) byte_load |-> $onehot(slot.mem_mask)
	);

endmodule

//--- slurm16_register_file.sv
`include "slurm16_params.svh"

module slurm16_register_file import slurm16_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_sel_t wr_sel,
	input word_t wr_data,
	input reg_sel_t rd_sel_a,
	input reg_sel_t rd_sel_b,
	output word_t raw_a,
	output word_t raw_b
);

	localparam int num_regs = 1 << `SLURM16_REGISTER_BITS;

	word_t regs [num_regs];

	// ##################################################
	// write port
	// ##################################################

	// r0 is stored like the rest, operand fetch masks it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			regs[wr_sel] <= wr_data;
		end
	end

	// ##################################################
	// read ports
	// ##################################################

	// asynchronous, old contents until the write edge
	assign raw_a = regs[rd_sel_a];
	assign raw_b = regs[rd_sel_b];

endmodule

//--- slurm16_operand_fetch.sv
module slurm16_operand_fetch import slurm16_pkg::*; (
	input reg_sel_t rd_sel_a,
	input reg_sel_t rd_sel_b,
	input word_t raw_a,
	input word_t raw_b,
	input reg_sel_t wr_sel,
	input word_t wr_data,
	output word_t operand_a,
	output word_t operand_b
);

	// one read port worth of r0 masking and bypass
	function automatic word_t resolve(
		reg_sel_t rd_sel,
		word_t raw,
		reg_sel_t byp_sel,
		word_t byp_data
	);
		word_t value;
		if (rd_sel == '0) begin
			value = '0;
		end else if (rd_sel == byp_sel) begin
			// value being written this cycle is not in the array yet
			value = byp_data;
		end else begin
			value = raw;
		end
		return value;
	endfunction

	// ##################################################
	// both read ports
	// ##################################################

	always_comb begin
		operand_a = resolve(rd_sel_a, raw_a, wr_sel, wr_data);
	end

	always_comb begin
		operand_b = resolve(rd_sel_b, raw_b, wr_sel, wr_data);
	end

endmodule

//--- slurm16_wb_top.sv
`include "slurm16_params.svh"

module slurm16_wb_top import slurm16_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic kill,
	input instr_t instruction,
	input word_t alu_out,
	input word_t memory_in,
	input word_t port_in,
	input logic [`SLURM16_ADDRESS_BITS-1:0] pc_stage3,
	input logic [1:0] mem_mask,
	input logic is_nop,
	input logic load_irq_ret,
	input logic cond_pass,
	input flags_t flags,
	input reg_sel_t rd_sel_a,
	input reg_sel_t rd_sel_b,
	output reg_sel_t reg_wr_sel,
	output word_t reg_out,
	output word_t operand_a,
	output word_t operand_b
);

	word_t raw_a;
	word_t raw_b;

	// stage 4 slot between latch and writeback
	slurm16_stage4_if u_slot (.clk(clk));

	slurm16_cpu_stage4 u_stage4 (
		.clk(clk), .rst_n(rst_n), .stall(stall), .kill(kill),
		.instruction(instruction), .alu_out(alu_out), .memory_in(memory_in),
		.port_in(port_in), .pc_stage3(pc_stage3), .mem_mask(mem_mask),
		.is_nop(is_nop), .load_irq_ret(load_irq_ret), .cond_pass(cond_pass),
		.flags(flags), .slot(u_slot.latch)
	);

	slurm16_cpu_writeback u_writeback (
		.slot(u_slot.wb), .reg_wr_sel(reg_wr_sel), .reg_out(reg_out)
	);

	slurm16_register_file u_regs (
		.clk(clk), .rst_n(rst_n), .wr_sel(reg_wr_sel), .wr_data(reg_out),
		.rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .raw_a(raw_a), .raw_b(raw_b)
	);

	slurm16_operand_fetch u_fetch (
		.rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .raw_a(raw_a), .raw_b(raw_b),
		.wr_sel(reg_wr_sel), .wr_data(reg_out),
		.operand_a(operand_a), .operand_b(operand_b)
	);

endmodule

//--- tb_slurm16_checker.sv
module tb_slurm16_checker import slurm16_pkg::*; (
	input logic clk,
	input logic check_en,
	input reg_sel_t exp_wr_sel,
	input word_t exp_out,
	input word_t exp_a,
	input word_t exp_b,
	input reg_sel_t reg_wr_sel,
	input word_t reg_out,
	input word_t operand_a,
	input word_t operand_b
);

	int errors = 0;
	int checks = 0;

	task automatic compare(string name, word_t got, word_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error t=%0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	// ##################################################
	// sampling
	// ##################################################

	// outputs follow the slot after the rising edge and hold until the next one,
	// so look one unit later, still ahead of the falling edge
	always begin
		@(posedge clk);
		#1;
		if (check_en) begin
			compare("reg_wr_sel", word_t'(reg_wr_sel), word_t'(exp_wr_sel));
			compare("reg_out", reg_out, exp_out);
			compare("operand_a", operand_a, exp_a);
			compare("operand_b", operand_b, exp_b);
		end
	end

endmodule

//--- tb_slurm16_wb.sv
`include "slurm16_params.svh"

module tb_slurm16_wb import slurm16_pkg::*; ();

	// one data line of the golden file
	typedef struct packed {
		logic stall;
		logic kill;
		instr_t instruction;
		word_t alu_out;
		word_t memory_in;
		word_t port_in;
		logic [`SLURM16_ADDRESS_BITS-1:0] pc;
		logic [1:0] mem_mask;
		logic is_nop;
		logic load_irq_ret;
		logic cond_pass;
		flags_t flags;
		logic [2:0] fill;
		reg_sel_t rd_sel_a;
		reg_sel_t rd_sel_b;
		reg_sel_t exp_wr_sel;
		word_t exp_out;
		word_t exp_a;
		word_t exp_b;
	} vector_t;

	localparam int reset_cycles = 10;

	logic clk = 1'b0;
	logic rst_n;
	logic stall;
	logic kill;
	instr_t instruction;
	word_t alu_out;
	word_t memory_in;
	word_t port_in;
	logic [`SLURM16_ADDRESS_BITS-1:0] pc_stage3;
	logic [1:0] mem_mask;
	logic is_nop;
	logic load_irq_ret;
	logic cond_pass;
	flags_t flags;
	reg_sel_t rd_sel_a;
	reg_sel_t rd_sel_b;
	reg_sel_t reg_wr_sel;
	word_t reg_out;
	word_t operand_a;
	word_t operand_b;

	logic check_en;
	reg_sel_t exp_wr_sel;
	word_t exp_out;
	word_t exp_a;
	word_t exp_b;

	vector_t vectors[$];
	int file_errors = 0;
	int run_limit = 0;
	int expected_checks = 0;

	always #2 clk = ~clk;

	slurm16_wb_top u_dut (.*);

	tb_slurm16_checker u_checker (
		.clk(clk), .check_en(check_en),
		.exp_wr_sel(exp_wr_sel), .exp_out(exp_out), .exp_a(exp_a), .exp_b(exp_b),
		.reg_wr_sel(reg_wr_sel), .reg_out(reg_out),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	// ##################################################
	// golden file
	// ##################################################

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [15:0] f [19];
		vector_t v;
		fd = $fopen("slurm16_wb_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open slurm16_wb_golden.txt");
			file_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// comment and blank lines carry no vector
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
					if (n != 19) begin
						$display("golden line has %0d fields instead of 19: %s", n, line);
						file_errors++;
					end else begin
						v.stall = f[0][0];
						v.kill = f[1][0];
						v.instruction = f[2];
						v.alu_out = f[3];
						v.memory_in = f[4];
						v.port_in = f[5];
						v.pc = f[6];
						v.mem_mask = f[7][1:0];
						v.is_nop = f[8][0];
						v.load_irq_ret = f[9][0];
						v.cond_pass = f[10][0];
						v.flags = flags_t'(f[11][3:0]);
						v.fill = f[12][2:0];
						v.rd_sel_a = f[13][6:0];
						v.rd_sel_b = f[14][6:0];
						v.exp_wr_sel = f[15][6:0];
						v.exp_out = f[16];
						v.exp_a = f[17];
						v.exp_b = f[18];
						vectors.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// fill bit 0 randomizes alu_out, bit 1 memory_in and bit 2 port_in
	task automatic apply_vector(vector_t v);
		stall = v.stall;
		kill = v.kill;
		instruction = v.instruction;
		alu_out = v.fill[0] ? word_t'($urandom()) : v.alu_out;
		memory_in = v.fill[1] ? word_t'($urandom()) : v.memory_in;
		port_in = v.fill[2] ? word_t'($urandom()) : v.port_in;
		pc_stage3 = v.pc;
		mem_mask = v.mem_mask;
		is_nop = v.is_nop;
		load_irq_ret = v.load_irq_ret;
		cond_pass = v.cond_pass;
		flags = v.flags;
		rd_sel_a = v.rd_sel_a;
		rd_sel_b = v.rd_sel_b;
		exp_wr_sel = v.exp_wr_sel;
		exp_out = v.exp_out;
		exp_a = v.exp_a;
		exp_b = v.exp_b;
		check_en = 1'b1;
	endtask

	// ##################################################
	// main sequence
	// ##################################################

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		kill = 1'b0;
		// the reset slot has to mask a live instruction and an interrupt return
		instruction = 16'h100f;
		alu_out = 16'hffff;
		memory_in = '0;
		port_in = '0;
		pc_stage3 = 16'h0abc;
		mem_mask = 2'b00;
		is_nop = 1'b0;
		load_irq_ret = 1'b1;
		cond_pass = 1'b0;
		flags = '0;
		rd_sel_a = reg_sel_t'(`SLURM16_LINK_REGISTER);
		rd_sel_b = reg_sel_t'(`SLURM16_INTERRUPT_LINK_REGISTER);
		check_en = 1'b1;
		exp_wr_sel = '0;
		exp_out = '0;
		exp_a = '0;
		exp_b = '0;
		void'($urandom(87));
		load_vectors();
		if (vectors.size() == 0 || file_errors != 0) begin
			$display("golden file did not give a usable set of vectors");
			$display("Test FAILED");
			$finish;
		end else begin
			expected_checks = 4 * (vectors.size() + reset_cycles);
			run_limit = vectors.size() * 4 + reset_cycles * 4 + 100;
			repeat (reset_cycles) @(negedge clk);
			rst_n = 1'b1;
			check_en = 1'b0;
			instruction = '0;
			alu_out = '0;
			pc_stage3 = '0;
			is_nop = 1'b1;
			load_irq_ret = 1'b0;
			rd_sel_a = '0;
			rd_sel_b = '0;
			foreach (vectors[i]) begin
				@(negedge clk);
				apply_vector(vectors[i]);
			end
			// last compare happened just before this edge
			@(negedge clk);
			check_en = 1'b0;
			if (u_checker.checks != expected_checks) begin
				$display("checker made %0d compares where %0d were due",
					u_checker.checks, expected_checks);
			end
			$display("vectors %0d, checks %0d, errors %0d",
				vectors.size(), u_checker.checks, u_checker.errors);
			if (u_checker.errors == 0 && u_checker.checks == expected_checks) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
			$finish;
		end
	end

	// watchdog arms once the vector count is known
	initial begin
		wait (run_limit != 0);
		#(run_limit);
		$display("timeout, run still going after %0d time units", run_limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+.
slurm16_pkg.sv
slurm16_stage4_if.sv
slurm16_cpu_stage4.sv
slurm16_cpu_writeback.sv
slurm16_register_file.sv
slurm16_operand_fetch.sv
slurm16_wb_top.sv
tb_slurm16_checker.sv
tb_slurm16_wb.sv

//--- run.sh
#!/bin/sh
# builds the writeback testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module tb_slurm16_wb \
	-o tb_slurm16_wb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_slurm16_wb_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Test FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation log has no pass message"; exit 1; }
echo "simulation passed"

//--- slurm16_wb_golden.txt
# stall kill instr alu_out memory_in port_in pc_stage3 mem_mask is_nop irq cond_pass flags(zcsv) fill
#   rd_sel_a rd_sel_b, then expected reg_wr_sel reg_out operand_a operand_b after the edge
0 0 0000 0000 0000 0000 0000 0 1 0 0 0 7 01 0e 00 0000 0000 0000
0 0 0000 0000 0000 0000 0000 0 1 0 0 0 7 0f 7f 00 0000 0000 0000
0 0 1003 1234 0000 0000 0000 0 0 0 0 0 6 03 00 03 1234 1234 0000
0 0 2050 a5a5 0000 0000 0000 0 0 0 0 0 6 03 05 05 a5a5 1234 a5a5
0 0 3070 0f0f 0000 0000 0000 0 0 0 0 0 6 05 07 07 0f0f a5a5 0f0f
0 0 4800 0000 0000 0000 0100 0 0 0 0 0 7 0f 07 0f 0102 0102 0f0f
0 0 4000 0000 0000 0000 0200 0 0 0 0 0 7 0f 00 00 0000 0102 0000
0 0 7090 0000 beef 0000 0000 0 0 0 0 0 5 09 03 09 beef beef 1234
0 0 7890 0000 0000 0000 0000 0 0 0 0 0 7 09 0f 00 0000 beef 0102
0 0 80a0 0000 0000 5a5a 0000 0 0 0 0 0 3 0a 05 0a 5a5a 5a5a a5a5
0 0 50b0 0000 8c34 0000 0000 2 0 0 0 0 5 0b 0a 0b 008c 008c 5a5a
0 0 50c0 0000 12f3 0000 0000 1 0 0 0 0 5 0c 0b 0c 00f3 00f3 008c
0 0 60d0 0000 9c01 0000 0000 2 0 0 0 0 5 0d 0c 0d ff9c ff9c 00f3
0 0 6010 0000 8077 0000 0000 1 0 0 0 0 5 01 0d 01 0077 0077 ff9c
0 0 6020 0000 7780 0000 0000 1 0 0 0 0 5 02 01 02 ff80 ff80 0077
0 0 6040 0000 7f00 0000 0000 2 0 0 0 0 5 04 02 04 007f 007f ff80
0 0 9060 1111 0000 0000 0000 0 0 0 0 8 6 06 04 06 1111 1111 007f
0 0 9160 2222 0000 0000 0000 0 0 0 0 8 6 06 00 00 0000 1111 0000
0 0 9b60 3333 0000 0000 0000 0 0 0 0 2 6 06 06 06 3333 3333 3333
0 0 9c80 4444 0000 0000 0000 0 0 0 0 8 6 06 03 00 0000 3333 1234
0 0 9880 4444 0000 0000 0000 0 0 0 0 4 6 08 06 08 4444 4444 3333
0 0 9f80 5555 0000 0000 0000 0 0 0 0 f 6 08 0f 00 0000 4444 0102
0 0 9a80 6666 0000 0000 0000 0 0 0 0 3 6 08 00 08 6666 6666 0000
0 0 9380 7777 0000 0000 0000 0 0 0 0 4 6 08 07 00 0000 6666 0f0f
0 0 a312 9abc 0000 0000 0000 0 0 0 1 0 6 03 01 03 9abc 9abc 0077
0 0 a512 def0 0000 0000 0000 0 0 0 0 0 6 03 05 00 0000 9abc a5a5
0 0 2070 1357 0000 0000 0a00 0 0 1 0 0 6 0e 07 0e 0a00 0a00 0f0f
0 0 0000 0000 0000 0000 0b10 0 1 1 0 0 7 0e 07 0e 0b10 0b10 0f0f
0 0 1007 2468 0000 0000 0000 0 0 0 0 0 6 07 0e 07 2468 2468 0b10
1 0 1009 ffff 0000 0000 0000 0 0 0 0 0 6 07 09 07 2468 2468 beef
0 1 1009 ffff 0000 0000 0000 0 0 0 0 0 6 09 07 00 0000 beef 2468
0 1 0000 0000 0000 0000 0c00 0 0 1 0 0 7 0e 00 00 0000 0b10 0000
0 0 1000 ffff 0000 0000 0000 0 0 0 0 0 6 00 00 00 ffff 0000 0000
0 0 0000 0000 0000 0000 0000 0 1 0 0 0 7 00 0d 00 0000 0000 ff9c
